/* rtl/mipsPkg.sv */
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Architectural sizes
    ////////////////////////////////////////////////////////////
    localparam int NUM_REGS = 32;
    localparam int XLEN     = 32;

    ////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE    = 6'b000000;
    localparam logic [5:0] OP_SPECIAL2 = 6'b011100;  // mul
    localparam logic [5:0] OP_SPECIAL3 = 6'b011111;  // seb, seh
    localparam logic [5:0] OP_ADDI     = 6'b001000;
    localparam logic [5:0] OP_ADDIU    = 6'b001001;
    localparam logic [5:0] OP_SLTI     = 6'b001010;
    localparam logic [5:0] OP_SLTIU    = 6'b001011;
    localparam logic [5:0] OP_ANDI     = 6'b001100;
    localparam logic [5:0] OP_ORI      = 6'b001101;
    localparam logic [5:0] OP_XORI     = 6'b001110;

    // Function codes of the R-type group
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;

    localparam logic [5:0] FN_MUL   = 6'b000010;  // Special2 group
    localparam logic [5:0] FN_BSHFL = 6'b100000;  // Special3 group
    localparam logic [4:0] SEB_SA   = 5'b10000;   // Selector in the shamt field
    localparam logic [4:0] SEH_SA   = 5'b11000;

    ////////////////////////////////////////////////////////////
    // Decoder and ALU encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        CLS_IDLE, CLS_RTYPE, CLS_MUL, CLS_BSHFL, CLS_ADD,
        CLS_AND, CLS_OR, CLS_XOR, CLS_SLT, CLS_SLTU
    } aluClass_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLT,
        SLTU, SLL, SRL, SRA, MUL, SEB, SEH
    } aluOp_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef struct packed {
        logic      regDst;    // 1 picks rt as destination
        logic      regWrite;
        logic      aluSrc;    // 1 picks the immediate
        logic      signExt;
        aluClass_e aluClass;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      regIdx;
        logic [XLEN-1:0] data;
    } wbReport_t;

    // No write, no report
    localparam ctrl_t CTRL_IDLE = '{regDst: 1'b0, regWrite: 1'b0, aluSrc: 1'b0,
                                    signExt: 1'b0, aluClass: CLS_IDLE};

endpackage

/* rtl/datapathController.sv */
`timescale 1ns/1ps

module datapathController import mipsPkg::*; (
    input  logic   instrValid,
    input  instr_t instr,
    output ctrl_t  ctrl
);

    ////////////////////////////////////////////////////////////
    // Main decode on the major opcode
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl = CTRL_IDLE;  // Also covers unknown opcodes
        if (instrValid) begin
            case (instr.opcode)
                OP_RTYPE: begin
                    ctrl = '{regDst: 1'b0, regWrite: 1'b1, aluSrc: 1'b0,
                             signExt: 1'b0, aluClass: CLS_RTYPE};
                end
                OP_SPECIAL2: begin
                    ctrl = '{regDst: 1'b0, regWrite: 1'b1, aluSrc: 1'b0,
                             signExt: 1'b0, aluClass: CLS_MUL};
                end
                // seb and seh write rd from rt
                OP_SPECIAL3: begin
                    ctrl = '{regDst: 1'b0, regWrite: 1'b1, aluSrc: 1'b0,
                             signExt: 1'b0, aluClass: CLS_BSHFL};
                end

                // Arithmetic immediates, sign extended
                OP_ADDI: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b1, aluClass: CLS_ADD};
                end
                OP_ADDIU: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b1, aluClass: CLS_ADD};
                end
                OP_SLTI: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b1, aluClass: CLS_SLT};
                end
                OP_SLTIU: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b1, aluClass: CLS_SLTU};
                end

                // Logic immediates, zero extended
                OP_ANDI: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b0, aluClass: CLS_AND};
                end
                OP_ORI: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b0, aluClass: CLS_OR};
                end
                OP_XORI: begin
                    ctrl = '{regDst: 1'b1, regWrite: 1'b1, aluSrc: 1'b1,
                             signExt: 1'b0, aluClass: CLS_XOR};
                end
                default: begin
                    ctrl = CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

/* rtl/aluControl.sv */
`timescale 1ns/1ps

module aluControl import mipsPkg::*; (
    input  aluClass_e aluClass,
    input  instr_t    instr,
    output aluOp_e    aluOp,
    output logic      opLegal
);

    always_comb begin
        aluOp   = ADD;
        opLegal = 1'b1;
        case (aluClass)
            CLS_RTYPE: begin
                case (instr.funct)
                    FN_ADD, FN_ADDU: aluOp = ADD;  // No overflow trap
                    FN_SUB, FN_SUBU: aluOp = SUB;
                    FN_AND:          aluOp = AND;
                    FN_OR:           aluOp = OR;
                    FN_XOR:          aluOp = XOR;
                    FN_NOR:          aluOp = NOR;
                    FN_SLT:          aluOp = SLT;
                    FN_SLTU:         aluOp = SLTU;
                    FN_SLL:          aluOp = SLL;
                    FN_SRL:          aluOp = SRL;
                    FN_SRA:          aluOp = SRA;
                    default:         opLegal = 1'b0;
                endcase
            end
            CLS_MUL: begin
                aluOp   = MUL;
                opLegal = (instr.funct == FN_MUL);
            end
            // Byte or half chosen by the shamt selector
            CLS_BSHFL: begin
                if (instr.funct == FN_BSHFL && instr.shamt == SEB_SA) begin
                    aluOp = SEB;
                end else if (instr.funct == FN_BSHFL && instr.shamt == SEH_SA) begin
                    aluOp = SEH;
                end else begin
                    opLegal = 1'b0;
                end
            end
            CLS_ADD:  aluOp = ADD;
            CLS_AND:  aluOp = AND;
            CLS_OR:   aluOp = OR;
            CLS_XOR:  aluOp = XOR;
            CLS_SLT:  aluOp = SLT;
            CLS_SLTU: aluOp = SLTU;
            default: begin
                opLegal = 1'b0;  // Idle class
            end
        endcase
    end

endmodule

/* rtl/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
    input  instr_t          instr,
    input  ctrl_t           ctrl,
    input  aluOp_e          aluOp,
    input  logic [XLEN-1:0] rsData,
    input  logic [XLEN-1:0] rtData,
    output logic [XLEN-1:0] result
);

    logic [15:0]     imm16;
    logic [XLEN-1:0] immExt;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] mulLow;
    logic [XLEN-1:0] sebVal;
    logic [XLEN-1:0] sehVal;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    // Immediate lives in the rd, shamt and funct fields
    assign imm16 = {instr.rd, instr.shamt, instr.funct};

    always_comb begin
        if (ctrl.signExt) begin
            immExt = {{(XLEN-16){imm16[15]}}, imm16};
        end else begin
            immExt = {{(XLEN-16){1'b0}}, imm16};
        end
    end

    assign opB = ctrl.aluSrc ? immExt : rtData;

    ////////////////////////////////////////////////////////////
    // Special operations
    ////////////////////////////////////////////////////////////

    // Low word of the signed product, sized to XLEN by context
    assign mulLow = $signed(rsData) * $signed(rtData);

    assign sebVal = {{(XLEN-8){rtData[7]}}, rtData[7:0]};
    assign sehVal = {{(XLEN-16){rtData[15]}}, rtData[15:0]};

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (aluOp)
            ADD:  result = rsData + opB;
            SUB:  result = rsData - opB;
            AND:  result = rsData & opB;
            OR:   result = rsData | opB;
            XOR:  result = rsData ^ opB;
            NOR:  result = ~(rsData | opB);

            // Compares give 0 or 1
            SLT: begin
                result = {{(XLEN-1){1'b0}}, ($signed(rsData) < $signed(opB))};
            end
            SLTU: begin
                result = {{(XLEN-1){1'b0}}, (rsData < opB)};
            end

            // Shift amount comes from shamt, value from rt
            SLL:  result = rtData << instr.shamt;
            SRL:  result = rtData >> instr.shamt;
            SRA:  result = $unsigned($signed(rtData) >>> instr.shamt);

            MUL:  result = mulLow;
            SEB:  result = sebVal;
            SEH:  result = sehVal;
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
    input  logic            Clk,
    input  logic            reset,
    input  logic [4:0]      raddrA,
    input  logic [4:0]      raddrB,
    output logic [XLEN-1:0] rdataA,
    output logic [XLEN-1:0] rdataB,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [XLEN-1:0] wdata,
    output wbReport_t       wb
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            doWrite;

    assign doWrite = we && (waddr != 5'd0);  // r0 stays zero

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            wb <= '0;
        end else begin
            if (doWrite) begin
                regs[waddr] <= wdata;
            end
            // One-cycle pulse per committed write
            wb.valid  <= doWrite;
            wb.regIdx <= waddr;
            wb.data   <= wdata;
        end
    end

    // Asynchronous reads
    assign rdataA = (raddrA == 5'd0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? '0 : regs[raddrB];

endmodule

/* rtl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic      Clk,
    input  logic      reset,
    input  logic      instrValid,
    input  instr_t    instr,
    output wbReport_t wb
);

    ctrl_t           ctrl;
    aluOp_e          aluOp;
    logic            opLegal;
    logic [XLEN-1:0] rsData;
    logic [XLEN-1:0] rtData;
    logic [XLEN-1:0] result;
    logic [4:0]      destIdx;
    logic            wrEn;

    assign destIdx = ctrl.regDst ? instr.rt : instr.rd;  // Immediates write rt
    assign wrEn    = ctrl.regWrite & opLegal;

    datapathController datapathController_inst (
        .instrValid (instrValid),
        .instr      (instr),
        .ctrl       (ctrl)
    );

    aluControl aluControl_inst (
        .aluClass (ctrl.aluClass),
        .instr    (instr),
        .aluOp    (aluOp),
        .opLegal  (opLegal)
    );

    executeUnit executeUnit_inst (
        .instr  (instr),
        .ctrl   (ctrl),
        .aluOp  (aluOp),
        .rsData (rsData),
        .rtData (rtData),
        .result (result)
    );

    registerFile registerFile_inst (
        .Clk    (Clk),
        .reset  (reset),
        .raddrA (instr.rs),
        .raddrB (instr.rt),
        .rdataA (rsData),
        .rdataB (rtData),
        .we     (wrEn),
        .waddr  (destIdx),
        .wdata  (result),
        .wb     (wb)
    );

endmodule

/* dv/mipsCore_asserts.sv */
`timescale 1ns/1ps

module mipsCore_asserts import mipsPkg::*; (
    input logic      Clk,
    input logic      reset,
    input logic      instrValid,
    input wbReport_t wb
);

    int failCount = 0;  // Failed assertion count

    resetClearsReport: assert property (@(posedge Clk) reset |=> !wb.valid)
        else begin
            $error("Writeback report valid in the cycle after reset");
            failCount++;
        end

    noReportForR0: assert property (@(posedge Clk) disable iff (reset)
        wb.valid |-> (wb.regIdx != 5'd0))
        else begin
            $error("Writeback report names register zero");
            failCount++;
        end

    // Each report belongs to an instruction one cycle earlier
    reportNeedsInstr: assert property (@(posedge Clk) disable iff (reset)
        wb.valid |-> $past(instrValid))
        else begin
            $error("Writeback report without a valid instruction");
            failCount++;
        end

endmodule

bind mipsCore mipsCore_asserts coreAsserts_inst (
    .Clk        (Clk),
    .reset      (reset),
    .instrValid (instrValid),
    .wb         (wb)
);

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*; ();

    logic            Clk;
    logic            reset;
    logic            instrValid;
    instr_t          instr;
    wbReport_t       wb;
    logic [XLEN-1:0] model [NUM_REGS];  // Reference register state
    wbReport_t       pendingExp;        // Report due after the next edge
    logic [5:0]      rFuncts [13];
    logic [5:0]      immOps [7];
    integer          seed;
    int              cycleCount;

    mipsCore mipsCore_inst (
        .Clk        (Clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .wb         (wb)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // About seven times the ~270 cycles of stimulus
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 2000) begin
            $display("Timeout: the run did not finish within 2000 cycles");
            $display("TEST FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // Stop at the first failed concurrent assertion
    always @(negedge Clk) begin
        if (mipsCore_inst.coreAsserts_inst.failCount != 0) begin
            $display("A concurrent assertion on the core failed");
            $display("TEST FAILED");
            $fatal(1, "Concurrent assertion failure in the core");
        end
    end

    ////////////////////////////////////////////////////////////
    // Encoding and reference model
    ////////////////////////////////////////////////////////////
    function automatic instr_t encodeR(input logic [5:0] op, fn,
                                       input logic [4:0] rd, rs, rt, sh);
        return instr_t'({op, rs, rt, rd, sh, fn});
    endfunction

    function automatic instr_t encodeI(input logic [5:0] op, input logic [4:0] rt, rs,
                                       input logic [15:0] imm);
        return instr_t'({op, rs, rt, imm});
    endfunction

    function automatic wbReport_t predict(input logic v, input instr_t ins);
        logic [XLEN-1:0] a, b, imm, r;
        logic [63:0]     prod;
        logic            ok;
        wbReport_t       rep;
        a    = model[ins.rs];
        b    = model[ins.rt];
        imm  = (ins.opcode[5:2] == 4'b0011) ? {16'h0, ins[15:0]}  // Logic ops zero extend
                                            : {{16{ins[15]}}, ins[15:0]};
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        ok   = v;
        r    = '0;
        case (ins.opcode)
            OP_RTYPE: begin
                case (ins.funct)
                    FN_ADD, FN_ADDU: r = a + b;
                    FN_SUB, FN_SUBU: r = a - b;
                    FN_AND:  r = a & b;
                    FN_OR:   r = a | b;
                    FN_XOR:  r = a ^ b;
                    FN_NOR:  r = ~(a | b);
                    FN_SLT:  r = ($signed(a) < $signed(b)) ? 1 : 0;
                    FN_SLTU: r = (a < b) ? 1 : 0;
                    FN_SLL:  r = b << ins.shamt;
                    FN_SRL:  r = b >> ins.shamt;
                    FN_SRA:  r = $signed(b) >>> ins.shamt;
                    default: ok = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                r  = prod[31:0];
                ok = ok && (ins.funct == FN_MUL);
            end
            OP_SPECIAL3: begin
                if (ins.funct == FN_BSHFL && ins.shamt == SEB_SA) begin
                    r = {{24{b[7]}}, b[7:0]};
                end else if (ins.funct == FN_BSHFL && ins.shamt == SEH_SA) begin
                    r = {{16{b[15]}}, b[15:0]};
                end else begin
                    ok = 1'b0;
                end
            end
            OP_ADDI, OP_ADDIU: r = a + imm;
            OP_SLTI:           r = ($signed(a) < $signed(imm)) ? 1 : 0;
            OP_SLTIU:          r = (a < imm) ? 1 : 0;
            OP_ANDI:           r = a & imm;
            OP_ORI:            r = a | imm;
            OP_XORI:           r = a ^ imm;
            default:           ok = 1'b0;
        endcase
        rep.regIdx = (ins.opcode[5:3] == 3'b001) ? ins.rt : ins.rd;  // I-type writes rt
        rep.valid  = ok && (rep.regIdx != 5'd0);
        rep.data   = r;
        return rep;
    endfunction

    ////////////////////////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////////////////////////
    task automatic checkReport(input wbReport_t exp);
        if (wb.valid !== 1'b1 || wb.regIdx !== exp.regIdx || wb.data !== exp.data) begin
            $display("Fail at %0t: report valid %b r%0d=%h, expected r%0d=%h",
                     $time, wb.valid, wb.regIdx, wb.data, exp.regIdx, exp.data);
            $display("TEST FAILED");
            $fatal(1, "Writeback report mismatch");
        end
    endtask

    task automatic checkIdle();
        if (wb.valid !== 1'b0) begin
            $display("Fail at %0t: unexpected report r%0d=%h", $time, wb.regIdx, wb.data);
            $display("TEST FAILED");
            $fatal(1, "Writeback report where none was due");
        end
    endtask

    task automatic step(input logic v, input instr_t ins);
        wbReport_t exp;
        @(posedge Clk);
        instrValid <= v;
        instr      <= ins;
        exp = predict(v, ins);
        if (exp.valid) begin
            model[exp.regIdx] = exp.data;
        end
        @(negedge Clk);  // Report of the previous step is stable here
        if (pendingExp.valid) begin
            checkReport(pendingExp);
        end else begin
            checkIdle();
        end
        pendingExp = exp;
    endtask

    task automatic issue(input instr_t ins);
        step(1'b1, ins);
    endtask

    // 32-bit constant from ori, sll, ori
    task automatic loadReg(input logic [4:0] idx, input logic [XLEN-1:0] value);
        issue(encodeI(OP_ORI, idx, 5'd0, value[31:16]));
        issue(encodeR(OP_RTYPE, FN_SLL, idx, 5'd0, idx, 5'd16));
        issue(encodeI(OP_ORI, idx, idx, value[15:0]));
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic testResetState();
        repeat (3) step(1'b0, '0);
        issue(encodeR(OP_RTYPE, FN_ADDU, 5'd1, 5'd0, 5'd0, 5'd0));
        issue(encodeR(OP_RTYPE, FN_ADDU, 5'd2, 5'd9, 5'd30, 5'd0));  // Untouched regs read zero
    endtask

    task automatic testImmediates();
        logic [15:0] imms [4];
        imms = '{16'h8001, 16'h7ffe, 16'hffff, 16'h0005};
        loadReg(5'd2, 32'hffff_fffb);  // -5
        loadReg(5'd3, 32'h0000_7fff);
        for (int s = 2; s <= 3; s++) begin
            for (int k = 0; k < 4; k++) begin
                for (int o = 0; o < 7; o++) begin
                    issue(encodeI(immOps[o], 5'd8 + 5'(o), 5'(s), imms[k]));
                end
            end
        end
    endtask

    task automatic testRtype();
        logic [4:0] sh;
        loadReg(5'd3, $random(seed) & 32'h7fff_ffff);  // Non-negative, so slt and sltu differ
        loadReg(5'd4, $random(seed) | 32'h8000_0000);  // Negative for sra and slt
        for (int f = 0; f < 13; f++) begin
            sh = rFuncts[f][5] ? 5'd0 : 5'd1 + 5'($unsigned($random(seed)) % 31);
            issue(encodeR(OP_RTYPE, rFuncts[f], 5'd10, 5'd3, 5'd4, sh));
            issue(encodeR(OP_RTYPE, rFuncts[f], 5'd11, 5'd4, 5'd3, sh));
        end
    endtask

    task automatic testMulExt();
        for (int i = 0; i < 4; i++) begin
            loadReg(5'd5, $random(seed));
            loadReg(5'd6, $random(seed));
            issue(encodeR(OP_SPECIAL2, FN_MUL, 5'd7, 5'd5, 5'd6, 5'd0));
            issue(encodeR(OP_SPECIAL3, FN_BSHFL, 5'd8, 5'd0, 5'd5, SEB_SA));
            issue(encodeR(OP_SPECIAL3, FN_BSHFL, 5'd9, 5'd0, 5'd6, SEH_SA));
        end
        loadReg(5'd5, 32'h1234_80f0);  // Bits 7 and 15 set
        issue(encodeR(OP_SPECIAL3, FN_BSHFL, 5'd8, 5'd0, 5'd5, SEB_SA));
        issue(encodeR(OP_SPECIAL3, FN_BSHFL, 5'd9, 5'd0, 5'd5, SEH_SA));
    endtask

    task automatic testSuppressed();
        loadReg(5'd5, 32'h5a5a_c3c3);
        issue(encodeI(OP_ADDIU, 5'd0, 5'd5, 16'h0011));              // Target r0
        issue(encodeR(OP_RTYPE, FN_ADDU, 5'd0, 5'd5, 5'd5, 5'd0));
        issue(encodeI(6'b111111, 5'd5, 5'd5, 16'h1234));             // Unknown opcode
        issue(encodeI(6'b000100, 5'd5, 5'd5, 16'h0001));             // beq not supported
        issue(encodeR(OP_RTYPE, 6'b111111, 5'd5, 5'd5, 5'd5, 5'd0)); // Unknown funct
        issue(encodeR(OP_SPECIAL2, 6'b000000, 5'd5, 5'd5, 5'd5, 5'd0));
        issue(encodeR(OP_SPECIAL3, FN_BSHFL, 5'd5, 5'd0, 5'd5, 5'b00010));
        step(1'b0, encodeI(OP_ADDIU, 5'd5, 5'd5, 16'h0001));         // Valid low
        issue(encodeR(OP_RTYPE, FN_ADDU, 5'd6, 5'd5, 5'd0, 5'd0));   // r5 unchanged
        issue(encodeR(OP_RTYPE, FN_ADDU, 5'd7, 5'd0, 5'd0, 5'd0));   // r0 still zero
    endtask

    task automatic testBackToBack();
        instr_t     ins;
        logic [4:0] prev;
        logic [4:0] dst;
        int         kind;
        prev = 5'd7;
        repeat (100) begin
            kind   = $unsigned($random(seed)) % 23;
            dst    = 5'd1 + 5'($unsigned($random(seed)) % 31);
            ins    = instr_t'($random(seed));
            ins.rs = prev;
            if (kind < 16) begin
                ins.opcode = (kind < 13) ? OP_RTYPE : (kind == 13) ? OP_SPECIAL2 : OP_SPECIAL3;
                ins.funct  = (kind < 13) ? rFuncts[kind] : (kind == 13) ? FN_MUL : FN_BSHFL;
                ins.rd     = dst;
                if (kind >= 14) begin
                    ins.shamt = (kind == 14) ? SEB_SA : SEH_SA;
                end
                // Shifts, seb and seh read only rt
                if (kind >= 14 || (kind < 13 && !ins.funct[5])) begin
                    ins.rt = prev;
                end
            end else begin
                ins.opcode = immOps[kind - 16];
                ins.rt     = dst;
            end
            issue(ins);
            prev = dst;
        end
        step(1'b0, '0);  // Collects the last report
    endtask

    initial begin
        seed       = 41049;
        cycleCount = 0;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pendingExp = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        rFuncts = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                    FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
        immOps  = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU};
        repeat (16) @(posedge Clk);
        reset <= 1'b0;
        testResetState();
        testImmediates();
        testRtype();
        testMulExt();
        testSuppressed();
        testBackToBack();
        if (mipsCore_inst.coreAsserts_inst.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Concurrent assertion failures in the core");
        end
    end

endmodule

/* list.f */
rtl/mipsPkg.sv
rtl/datapathController.sv
rtl/aluControl.sv
rtl/executeUnit.sv
rtl/registerFile.sv
rtl/mipsCore.sv
dv/mipsCore_asserts.sv
dv/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - rtl/mipsPkg.sv
  - rtl/datapathController.sv
  - rtl/aluControl.sv
  - rtl/executeUnit.sv
  - rtl/registerFile.sv
  - rtl/mipsCore.sv
  - target: test
    files:
      - dv/mipsCore_asserts.sv
      - dv/mipsCoreTb.sv
